//--- verilog/tetris_macros.svh
`ifndef TETRIS_MACROS_SVH
`define TETRIS_MACROS_SVH

// Playfield size in cells
`define FIELD_COLS 10
`define FIELD_ROWS 22

// Top rows that never reach the screen
`define HIDDEN_ROWS 2

// Square cell edge in pixels
`define CELL_PX 20

// Pixel origin of column 0, row 0
`define FIELD_X0 220
`define FIELD_Y0 20

// Pivot of a freshly spawned piece
`define SPAWN_X 3
`define SPAWN_Y 2

`define FIELD_CELLS 220

`endif

//--- verilog/tetris_pkg.sv
`default_nettype none

package tetris_pkg;

  typedef logic [4:0] cell_x_t;
  typedef logic [4:0] cell_y_t;
  typedef logic [9:0] pixel_coord_t;

  // Red in the top nibble, blue in the bottom one
  typedef logic [11:0] rgb_t;

  // Zero is an empty cell, anything else is piece kind plus one
  typedef logic [2:0] cell_code_t;

  // Offset of a piece cell from its pivot
  typedef logic [1:0] offset_t;

  typedef enum logic [2:0] {
    KIND_I, KIND_O, KIND_L, KIND_J, KIND_S, KIND_Z, KIND_T
  } piece_kind_t;

  typedef enum logic [1:0] {
    MOVE_STAY, MOVE_LEFT, MOVE_RIGHT, MOVE_DOWN
  } move_t;

  typedef enum logic [2:0] {
    ST_CLEAR, ST_WAIT_START, ST_SPAWN, ST_PLAY, ST_LOCK
  } game_state_t;

endpackage

`default_nettype wire

//--- verilog/shape_rom.sv
`timescale 1ns/100ps
`default_nettype none

module shape_rom import tetris_pkg::*; (
  input  piece_kind_t   kind,
  output offset_t [3:0] dx,
  output offset_t [3:0] dy
);

  // Entries listed cell 3 down to cell 0
  always_comb begin
    case (kind)
      KIND_O: begin
        dx = {2'd2, 2'd2, 2'd1, 2'd1};
        dy = {2'd1, 2'd0, 2'd1, 2'd0};
      end
      KIND_L: begin
        dx = {2'd2, 2'd1, 2'd1, 2'd1};
        dy = {2'd2, 2'd2, 2'd1, 2'd0};
      end
      KIND_J: begin
        dx = {2'd2, 2'd1, 2'd2, 2'd2};
        dy = {2'd2, 2'd2, 2'd1, 2'd0};
      end
      KIND_S: begin
        dx = {2'd2, 2'd1, 2'd1, 2'd0};
        dy = {2'd0, 2'd0, 2'd1, 2'd1};
      end
      KIND_Z: begin
        dx = {2'd2, 2'd1, 2'd1, 2'd0};
        dy = {2'd1, 2'd1, 2'd0, 2'd0};
      end
      KIND_T: begin
        dx = {2'd2, 2'd1, 2'd1, 2'd0};
        dy = {2'd1, 2'd1, 2'd0, 2'd1};
      end
      // Horizontal bar
      default: begin
        dx = {2'd3, 2'd2, 2'd1, 2'd0};
        dy = {2'd0, 2'd0, 2'd0, 2'd0};
      end
    endcase
  end

endmodule

`default_nettype wire

//--- verilog/cell_probe.sv
`timescale 1ns/100ps
`default_nettype none
`include "tetris_macros.svh"

module cell_probe import tetris_pkg::*; (
  input  cell_x_t    pivot_x,
  input  cell_y_t    pivot_y,
  input  offset_t    dx,
  input  offset_t    dy,
  input  move_t      move,
  input  cell_code_t probe_code,
  output cell_x_t    cell_x,
  output cell_y_t    cell_y,
  output cell_x_t    probe_x,
  output cell_y_t    probe_y,
  output logic       blocked
);

  // One spare bit, so a step left of column 0 wraps to 63
  logic [5:0] cand_x;
  logic [5:0] cand_y;

  assign cell_x = pivot_x + cell_x_t'(dx);
  assign cell_y = pivot_y + cell_y_t'(dy);

  always_comb begin
    cand_x = {1'b0, cell_x};
    cand_y = {1'b0, cell_y};
    case (move)
      MOVE_LEFT:  cand_x = {1'b0, cell_x} - 6'd1;
      MOVE_RIGHT: cand_x = {1'b0, cell_x} + 6'd1;
      MOVE_DOWN:  cand_y = {1'b0, cell_y} + 6'd1;
      default: ;
    endcase
  end

  assign probe_x = cand_x[4:0];
  assign probe_y = cand_y[4:0];

  // Walls, floor, then a locked cell in the way
  assign blocked = (cand_x >= 6'(`FIELD_COLS)) ||
                   (cand_y >= 6'(`FIELD_ROWS)) ||
                   (probe_code != '0);

endmodule

`default_nettype wire

//--- verilog/field_store.sv
`timescale 1ns/100ps
`default_nettype none
`include "tetris_macros.svh"

module field_store import tetris_pkg::*; (
  input  logic             VGA_CTRL_CLK,
  input  logic             RST,
  input  logic             wr_en,
  input  cell_x_t          wr_x,
  input  cell_y_t          wr_y,
  input  cell_code_t       wr_code,
  input  cell_x_t    [3:0] probe_x,
  input  cell_y_t    [3:0] probe_y,
  input  cell_x_t          render_x,
  input  cell_y_t          render_y,
  output cell_code_t [3:0] probe_code,
  output cell_code_t       render_code
);

  cell_code_t cells [`FIELD_CELLS];

  function automatic logic in_field(cell_x_t x, cell_y_t y);
    return (x < 5'(`FIELD_COLS)) && (y < 5'(`FIELD_ROWS));
  endfunction

  // Row major
  function automatic logic [7:0] cell_index(cell_x_t x, cell_y_t y);
    return 8'(y) * 8'(`FIELD_COLS) + 8'(x);
  endfunction

  // Anything off the grid reads as empty
  always_comb begin
    for (int i = 0; i < 4; i++) begin
      probe_code[i] = in_field(probe_x[i], probe_y[i]) ?
                      cells[cell_index(probe_x[i], probe_y[i])] : '0;
    end
    render_code = in_field(render_x, render_y) ?
                  cells[cell_index(render_x, render_y)] : '0;
  end

  always_ff @(posedge VGA_CTRL_CLK) begin
    if (wr_en) begin
      cells[cell_index(wr_x, wr_y)] <= wr_code;
    end
  end

  // Clear walk and lock writes both stay on the grid
  wr_in_field_a: assert property (@(posedge VGA_CTRL_CLK) disable iff (!RST)
    wr_en |-> in_field(wr_x, wr_y));

endmodule

`default_nettype wire

//--- verilog/piece_controller.sv
`timescale 1ns/100ps
`default_nettype none
`include "tetris_macros.svh"

module piece_controller import tetris_pkg::*; (
  input  logic          VGA_CTRL_CLK,
  input  logic          RST,
  input  logic          game_start,
  input  logic    [2:0] piece_sel,
  input  logic          move_left,
  input  logic          move_right,
  input  logic          drop_tick,
  input  logic    [3:0] blocked,
  input  cell_x_t [3:0] cell_x,
  input  cell_y_t [3:0] cell_y,
  output piece_kind_t   kind,
  output cell_x_t       pivot_x,
  output cell_y_t       pivot_y,
  output move_t         move,
  output logic          wr_en,
  output cell_x_t       wr_x,
  output cell_y_t       wr_y,
  output cell_code_t    wr_code,
  output logic          ready
);

  game_state_t state;
  cell_x_t     clear_x;
  cell_y_t     clear_y;
  logic  [2:0] lock_cnt;
  logic        move_ok;

  // Left wins over right, right over gravity
  always_comb begin
    move = MOVE_STAY;
    if (state == ST_PLAY) begin
      if (move_left) begin
        move = MOVE_LEFT;
      end else if (move_right) begin
        move = MOVE_RIGHT;
      end else if (drop_tick) begin
        move = MOVE_DOWN;
      end
    end
  end

  assign move_ok = ~|blocked;

  always_ff @(posedge VGA_CTRL_CLK or negedge RST) begin
    if (!RST) begin
      state    <= ST_CLEAR;
      clear_x  <= '0;
      clear_y  <= '0;
      lock_cnt <= '0;
      kind     <= KIND_I;
      pivot_x  <= cell_x_t'(`SPAWN_X);
      pivot_y  <= cell_y_t'(`SPAWN_Y);
      ready    <= 1'b0;
      wr_en    <= 1'b0;
    end else begin
      wr_en <= 1'b0;
      case (state)
        // One cell per cycle, column first
        ST_CLEAR: begin
          wr_en <= 1'b1;
          if (clear_x == cell_x_t'(`FIELD_COLS - 1)) begin
            clear_x <= '0;
            if (clear_y == cell_y_t'(`FIELD_ROWS - 1)) begin
              state <= ST_WAIT_START;
            end else begin
              clear_y <= clear_y + 1'b1;
            end
          end else begin
            clear_x <= clear_x + 1'b1;
          end
        end
        ST_WAIT_START: begin
          if (game_start) begin
            state <= ST_SPAWN;
          end
        end
        ST_SPAWN: begin
          // Select value 7 has no shape of its own
          kind    <= (piece_sel == 3'd7) ? KIND_I : piece_kind_t'(piece_sel);
          pivot_x <= cell_x_t'(`SPAWN_X);
          pivot_y <= cell_y_t'(`SPAWN_Y);
          ready   <= 1'b1;
          state   <= ST_PLAY;
        end
        ST_PLAY: begin
          case (move)
            MOVE_LEFT: begin
              if (move_ok) begin
                pivot_x <= pivot_x - 1'b1;
              end
            end
            MOVE_RIGHT: begin
              if (move_ok) begin
                pivot_x <= pivot_x + 1'b1;
              end
            end
            MOVE_DOWN: begin
              if (move_ok) begin
                pivot_y <= pivot_y + 1'b1;
              end else begin
                lock_cnt <= '0;
                ready    <= 1'b0;
                state    <= ST_LOCK;
              end
            end
            default: ;
          endcase
        end
        ST_LOCK: begin
          wr_en <= 1'b1;
          if (lock_cnt == 3'd3) begin
            lock_cnt <= '0;
            state    <= ST_SPAWN;
          end else begin
            lock_cnt <= lock_cnt + 1'b1;
          end
        end
        default: state <= ST_CLEAR;
      endcase
    end
  end

  // Address and code land on the same edge as wr_en
  always_ff @(posedge VGA_CTRL_CLK) begin
    if (state == ST_LOCK) begin
      wr_x    <= cell_x[lock_cnt[1:0]];
      wr_y    <= cell_y[lock_cnt[1:0]];
      wr_code <= cell_code_t'(kind + 3'd1);
    end else begin
      wr_x    <= clear_x;
      wr_y    <= clear_y;
      wr_code <= '0;
    end
  end

  ready_in_play_a: assert property (@(posedge VGA_CTRL_CLK) disable iff (!RST)
    ready |-> (state == ST_PLAY));

  lock_cnt_range_a: assert property (@(posedge VGA_CTRL_CLK) disable iff (!RST)
    lock_cnt < 3'd4);

endmodule

`default_nettype wire

//--- verilog/pixel_renderer.sv
`timescale 1ns/100ps
`default_nettype none
`include "tetris_macros.svh"

module pixel_renderer import tetris_pkg::*; (
  input  pixel_coord_t  px,
  input  pixel_coord_t  py,
  input  cell_x_t [3:0] cell_x,
  input  cell_y_t [3:0] cell_y,
  input  piece_kind_t   kind,
  input  cell_code_t    render_code,
  output cell_x_t       render_x,
  output cell_y_t       render_y,
  output rgb_t          pixel_rgb
);

  localparam pixel_coord_t X_LO = pixel_coord_t'(`FIELD_X0);
  localparam pixel_coord_t X_HI = pixel_coord_t'(`FIELD_X0 + `FIELD_COLS * `CELL_PX);
  // Window starts below the hidden rows
  localparam pixel_coord_t Y_LO = pixel_coord_t'(`FIELD_Y0 + `HIDDEN_ROWS * `CELL_PX);
  localparam pixel_coord_t Y_HI = pixel_coord_t'(`FIELD_Y0 + `FIELD_ROWS * `CELL_PX);

  logic       in_window;
  logic       piece_hit;
  cell_code_t shown_code;

  function automatic rgb_t code_to_rgb(cell_code_t code);
    case (code)
      3'd1:    return 12'h0FF;
      3'd2:    return 12'hFF0;
      3'd3:    return 12'hFA0;
      3'd4:    return 12'h00F;
      3'd5:    return 12'h0F0;
      3'd6:    return 12'hF00;
      3'd7:    return 12'hF0F;
      default: return 12'hFFF;
    endcase
  endfunction

  assign render_x = cell_x_t'((px - X_LO) / pixel_coord_t'(`CELL_PX));
  assign render_y = cell_y_t'((py - pixel_coord_t'(`FIELD_Y0)) / pixel_coord_t'(`CELL_PX));

  assign in_window = (px >= X_LO) && (px < X_HI) && (py >= Y_LO) && (py < Y_HI);

  // Active piece drawn over the locked cells
  always_comb begin
    piece_hit = 1'b0;
    for (int i = 0; i < 4; i++) begin
      if ((cell_x[i] == render_x) && (cell_y[i] == render_y)) begin
        piece_hit = 1'b1;
      end
    end
    shown_code = piece_hit ? cell_code_t'(kind + 3'd1) : render_code;
  end

  assign pixel_rgb = in_window ? code_to_rgb(shown_code) : 12'h000;

endmodule

`default_nettype wire

//--- verilog/tetris_top.sv
`timescale 1ns/100ps
`default_nettype none

module tetris_top import tetris_pkg::*; (
  input  logic         VGA_CTRL_CLK,
  input  logic         RST,
  input  logic         game_start,
  input  logic [2:0]   piece_sel,
  input  logic         move_left,
  input  logic         move_right,
  input  logic         drop_tick,
  input  pixel_coord_t px,
  input  pixel_coord_t py,
  output rgb_t         pixel_rgb,
  output logic         ready
);

  piece_kind_t      kind;
  offset_t    [3:0] dx;
  offset_t    [3:0] dy;
  cell_x_t          pivot_x;
  cell_y_t          pivot_y;
  move_t            move;
  cell_x_t    [3:0] cell_x;
  cell_y_t    [3:0] cell_y;
  cell_x_t    [3:0] probe_x;
  cell_y_t    [3:0] probe_y;
  cell_code_t [3:0] probe_code;
  logic       [3:0] blocked;
  logic             wr_en;
  cell_x_t          wr_x;
  cell_y_t          wr_y;
  cell_code_t       wr_code;
  cell_x_t          render_x;
  cell_y_t          render_y;
  cell_code_t       render_code;

  shape_rom u_shape_rom (
    .kind (kind),
    .dx   (dx),
    .dy   (dy)
  );

  // One probe per piece cell, all checked in the same cycle
  for (genvar i = 0; i < 4; i++) begin : g_probe
    cell_probe u_probe (
      .pivot_x    (pivot_x),
      .pivot_y    (pivot_y),
      .dx         (dx[i]),
      .dy         (dy[i]),
      .move       (move),
      .probe_code (probe_code[i]),
      .cell_x     (cell_x[i]),
      .cell_y     (cell_y[i]),
      .probe_x    (probe_x[i]),
      .probe_y    (probe_y[i]),
      .blocked    (blocked[i])
    );
  end

  field_store u_field_store (
    .VGA_CTRL_CLK (VGA_CTRL_CLK),
    .RST          (RST),
    .wr_en        (wr_en),
    .wr_x         (wr_x),
    .wr_y         (wr_y),
    .wr_code      (wr_code),
    .probe_x      (probe_x),
    .probe_y      (probe_y),
    .render_x     (render_x),
    .render_y     (render_y),
    .probe_code   (probe_code),
    .render_code  (render_code)
  );

  piece_controller u_piece_controller (
    .VGA_CTRL_CLK (VGA_CTRL_CLK),
    .RST          (RST),
    .game_start   (game_start),
    .piece_sel    (piece_sel),
    .move_left    (move_left),
    .move_right   (move_right),
    .drop_tick    (drop_tick),
    .blocked      (blocked),
    .cell_x       (cell_x),
    .cell_y       (cell_y),
    .kind         (kind),
    .pivot_x      (pivot_x),
    .pivot_y      (pivot_y),
    .move         (move),
    .wr_en        (wr_en),
    .wr_x         (wr_x),
    .wr_y         (wr_y),
    .wr_code      (wr_code),
    .ready        (ready)
  );

  pixel_renderer u_pixel_renderer (
    .px          (px),
    .py          (py),
    .cell_x      (cell_x),
    .cell_y      (cell_y),
    .kind        (kind),
    .render_code (render_code),
    .render_x    (render_x),
    .render_y    (render_y),
    .pixel_rgb   (pixel_rgb)
  );

endmodule

`default_nettype wire

//--- verification/tetris_tb.sv
`timescale 1ns/100ps
`default_nettype none
`include "tetris_macros.svh"

module tetris_tb;

  localparam int NUM_PIECES = 16;
  localparam int MV_LEFT    = 1;
  localparam int MV_RIGHT   = 2;
  localparam int MV_DOWN    = 3;

  logic        VGA_CTRL_CLK;
  logic        RST;
  logic        game_start;
  logic  [2:0] piece_sel;
  logic        move_left;
  logic        move_right;
  logic        drop_tick;
  logic  [9:0] px;
  logic  [9:0] py;
  logic [11:0] pixel_rgb;
  logic        ready;

  // Model of the locked cells and the active piece
  logic [2:0] field_m [`FIELD_ROWS][`FIELD_COLS];
  int         kind_m;
  int         pivx_m;
  int         pivy_m;

  logic [31:0] lcg;
  logic        check_pending;
  int          pixel_errors;
  int          ready_errors;
  int          timeouts;

  tetris_top uut (
    .VGA_CTRL_CLK (VGA_CTRL_CLK),
    .RST          (RST),
    .game_start   (game_start),
    .piece_sel    (piece_sel),
    .move_left    (move_left),
    .move_right   (move_right),
    .drop_tick    (drop_tick),
    .px           (px),
    .py           (py),
    .pixel_rgb    (pixel_rgb),
    .ready        (ready)
  );

  always #4 VGA_CTRL_CLK = ~VGA_CTRL_CLK;

  function automatic logic [31:0] lcg_step(logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
  endfunction

  // Offsets from the pivot, kinds in the order I O L J S Z T
  function automatic int off_x(int k, int i);
    int t [4];
    case (k)
      1:       t = '{1, 1, 2, 2};
      2:       t = '{1, 1, 1, 2};
      3:       t = '{2, 2, 1, 2};
      4, 5, 6: t = '{0, 1, 1, 2};
      default: t = '{0, 1, 2, 3};
    endcase
    return t[i];
  endfunction

  function automatic int off_y(int k, int i);
    int t [4];
    case (k)
      1:       t = '{0, 1, 0, 1};
      2, 3:    t = '{0, 1, 2, 2};
      4:       t = '{1, 1, 0, 0};
      5:       t = '{0, 0, 1, 1};
      6:       t = '{1, 0, 1, 1};
      default: t = '{0, 0, 0, 0};
    endcase
    return t[i];
  endfunction

  function automatic logic [11:0] code_colour(int code);
    case (code)
      1:       return 12'h0FF;
      2:       return 12'hFF0;
      3:       return 12'hFA0;
      4:       return 12'h00F;
      5:       return 12'h0F0;
      6:       return 12'hF00;
      7:       return 12'hF0F;
      default: return 12'hFFF;
    endcase
  endfunction

  function automatic logic move_blocked(int dxm, int dym);
    int   cx;
    int   cy;
    logic blk;
    blk = 1'b0;
    for (int i = 0; i < 4; i++) begin
      cx = pivx_m + off_x(kind_m, i) + dxm;
      cy = pivy_m + off_y(kind_m, i) + dym;
      if (cx < 0 || cx >= `FIELD_COLS || cy >= `FIELD_ROWS) begin
        blk = 1'b1;
      end else if (field_m[cy][cx] != 3'd0) begin
        blk = 1'b1;
      end
    end
    return blk;
  endfunction

  // Expected colour of any screen pixel
  function automatic logic [11:0] ref_pixel(int x, int y);
    int col;
    int row;
    int code;
    if (x < `FIELD_X0 || x >= `FIELD_X0 + `FIELD_COLS * `CELL_PX ||
        y < `FIELD_Y0 + `HIDDEN_ROWS * `CELL_PX ||
        y >= `FIELD_Y0 + `FIELD_ROWS * `CELL_PX) begin
      return 12'h000;
    end
    col  = (x - `FIELD_X0) / `CELL_PX;
    row  = (y - `FIELD_Y0) / `CELL_PX;
    code = field_m[row][col];
    for (int i = 0; i < 4; i++) begin
      if (pivx_m + off_x(kind_m, i) == col && pivy_m + off_y(kind_m, i) == row) begin
        code = kind_m + 1;
      end
    end
    return code_colour(code);
  endfunction

  task automatic clear_field_model;
    for (int r = 0; r < `FIELD_ROWS; r++) begin
      for (int c = 0; c < `FIELD_COLS; c++) begin
        field_m[r][c] = 3'd0;
      end
    end
  endtask

  task automatic lock_piece_model;
    for (int i = 0; i < 4; i++) begin
      field_m[pivy_m + off_y(kind_m, i)][pivx_m + off_x(kind_m, i)] = 3'(kind_m + 1);
    end
  endtask

  task automatic spawn_model(logic [2:0] sel);
    kind_m = (sel == 3'd7) ? 0 : int'(sel);
    pivx_m = `SPAWN_X;
    pivy_m = `SPAWN_Y;
  endtask

  task automatic sample_pixel(int x, int y);
    logic [11:0] want;
    px = 10'(x);
    py = 10'(y);
    #2;
    want = ref_pixel(x, y);
    if (pixel_rgb !== want) begin
      pixel_errors++;
      $display("** Error pixel_rgb at px=%h py=%h: got %h, expected %h",
               px, py, pixel_rgb, want);
    end
    @(negedge VGA_CTRL_CLK);
  endtask

  // Every cell centre, then the corners of the visible window
  task automatic sweep_screen;
    int ex [6];
    int ey [6];
    ex = '{0, 219, 220, 419, 420, 639};
    ey = '{0, 59, 60, 459, 460, 479};
    for (int r = 0; r < `FIELD_ROWS; r++) begin
      for (int c = 0; c < `FIELD_COLS; c++) begin
        sample_pixel(`FIELD_X0 + c * `CELL_PX + 10, `FIELD_Y0 + r * `CELL_PX + 10);
      end
    end
    for (int i = 0; i < 6; i++) begin
      for (int j = 0; j < 6; j++) begin
        sample_pixel(ex[i], ey[j]);
      end
    end
  endtask

  initial begin : compare_proc
    forever begin
      @(negedge VGA_CTRL_CLK);
      if (check_pending) begin
        sweep_screen();
        check_pending = 1'b0;
      end
    end
  end

  task automatic run_check;
    int waited;
    waited = 0;
    check_pending = 1'b1;
    while (check_pending && waited < 400) begin
      @(negedge VGA_CTRL_CLK);
      waited++;
    end
    if (check_pending) begin
      $display("Timeout: pixel sweep did not finish within 400 cycles");
      timeouts++;
      check_pending = 1'b0;
    end
  endtask

  task automatic do_step(int mv, logic [2:0] next_sel, output logic locked);
    int   dxm;
    int   dym;
    int   low;
    logic blk;
    dxm = (mv == MV_LEFT) ? -1 : ((mv == MV_RIGHT) ? 1 : 0);
    dym = (mv == MV_DOWN) ? 1 : 0;
    blk = move_blocked(dxm, dym);
    locked     = 1'b0;
    move_left  = (mv == MV_LEFT);
    move_right = (mv == MV_RIGHT);
    drop_tick  = (mv == MV_DOWN);
    @(negedge VGA_CTRL_CLK);
    move_left  = 1'b0;
    move_right = 1'b0;
    drop_tick  = 1'b0;
    if (blk && mv == MV_DOWN) begin
      lock_piece_model();
      locked    = 1'b1;
      piece_sel = next_sel;
      low       = 0;
      while (ready !== 1'b1 && low < 50) begin
        // All strobes during the first lock cycles, none may take effect
        move_left  = (low < 3);
        move_right = (low < 3);
        drop_tick  = (low < 3);
        @(negedge VGA_CTRL_CLK);
        low++;
      end
      move_left  = 1'b0;
      move_right = 1'b0;
      drop_tick  = 1'b0;
      if (ready !== 1'b1) begin
        $display("Timeout: ready did not return within 50 cycles after a lock");
        timeouts++;
      end else if (low != 5) begin
        $display("** Error ready low cycles after lock: got %h, expected %h", low, 5);
        ready_errors++;
      end
      spawn_model(next_sel);
    end else begin
      if (!blk) begin
        pivx_m += dxm;
        pivy_m += dym;
      end
      if (ready !== 1'b1) begin
        $display("** Error ready after move: got %h, expected %h", ready, 1'b1);
        ready_errors++;
      end
    end
    run_check();
  endtask

  initial begin : stimulus
    logic       locked;
    logic [2:0] sel;
    int         steps;
    int         mv;
    VGA_CTRL_CLK  = 1'b0;
    RST           = 1'b0;
    game_start    = 1'b0;
    piece_sel     = 3'd0;
    move_left     = 1'b0;
    move_right    = 1'b0;
    drop_tick     = 1'b0;
    px            = '0;
    py            = '0;
    check_pending = 1'b0;
    pixel_errors  = 0;
    ready_errors  = 0;
    timeouts      = 0;
    lcg           = 32'hb1fd85d9;
    clear_field_model();
    spawn_model(3'd0);
    repeat (3) @(negedge VGA_CTRL_CLK);
    RST = 1'b1;
    if (ready !== 1'b0) begin
      $display("** Error ready after reset: got %h, expected %h", ready, 1'b0);
      ready_errors++;
    end
    game_start = 1'b1;
    steps = 0;
    while (ready !== 1'b1 && steps < 1000) begin
      @(negedge VGA_CTRL_CLK);
      steps++;
    end
    if (ready !== 1'b1) begin
      $display("Timeout: ready never rose after the field clear");
      timeouts++;
    end else begin
      run_check();
      // Bar against the left wall, then the right one
      for (int i = 0; i < 4; i++) begin
        do_step(MV_LEFT, 3'd0, locked);
      end
      for (int i = 0; i < 7; i++) begin
        do_step(MV_RIGHT, 3'd0, locked);
      end
      // First seven spawns walk through every kind
      for (int p = 1; p < NUM_PIECES && timeouts == 0; p++) begin
        if (p < 8) begin
          sel = 3'(p);
        end else begin
          lcg = lcg_step(lcg);
          sel = lcg[18:16];
        end
        locked = 1'b0;
        steps  = 0;
        while (!locked && steps < 200 && timeouts == 0) begin
          lcg = lcg_step(lcg);
          case (lcg[17:16])
            2'd2:    mv = MV_LEFT;
            2'd3:    mv = MV_RIGHT;
            default: mv = MV_DOWN;
          endcase
          do_step(mv, sel, locked);
          steps++;
        end
      end
      // A second reset wipes the stacked cells before play resumes
      if (timeouts == 0) begin
        piece_sel = 3'd5;
        RST       = 1'b0;
        repeat (3) @(negedge VGA_CTRL_CLK);
        RST = 1'b1;
        clear_field_model();
        spawn_model(3'd5);
        steps = 0;
        while (ready !== 1'b1 && steps < 1000) begin
          @(negedge VGA_CTRL_CLK);
          steps++;
        end
        if (ready !== 1'b1) begin
          $display("Timeout: ready never rose after the second field clear");
          timeouts++;
        end else begin
          run_check();
        end
      end
    end
    $display("Errors: pixel %0d, ready %0d, timeout %0d",
             pixel_errors, ready_errors, timeouts);
    if (pixel_errors + ready_errors + timeouts == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- project.f
+incdir+verilog
verilog/tetris_pkg.sv
verilog/shape_rom.sv
verilog/cell_probe.sv
verilog/field_store.sv
verilog/piece_controller.sv
verilog/pixel_renderer.sv
verilog/tetris_top.sv
verification/tetris_tb.sv

//--- Makefile
VERILATOR ?= verilator
FILELIST  ?= project.f
TOP       ?= tetris_tb
RTL_TOP   ?= tetris_top
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing --assert -Wno-fatal
LINTFLAGS ?= --lint-only -Wall

RTL_SRCS := $(shell grep '^verilog/.*\.sv$$' $(FILELIST))

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

run: build
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -q "^Result: PASSED" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) +incdir+verilog $(RTL_SRCS) --top-module $(RTL_TOP)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
